/* hw/tc08_iot_pkg.sv */
`default_nettype none

package tc08_iot_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths.
	////////////////////////////////////////////////////////////

	localparam int WORD_W = 12;
	localparam int DEV_W  = 6;

	// Bit 0 is the most significant bit, as on the host.
	typedef logic [0:WORD_W-1] word_t;
	typedef logic [DEV_W-1:0]  dev_code_t;

	// Positions of the three IOT pulses in the pulse vector.
	localparam int IOP1 = 0;
	localparam int IOP2 = 1;
	localparam int IOP4 = 2;

	////////////////////////////////////////////////////////////
	// Status register A, in AC bit numbers.
	////////////////////////////////////////////////////////////

	localparam int SA_UNIT_MSB = 0;
	localparam int SA_UNIT_LSB = 2;
	localparam int SA_REV      = 3;  // Reverse direction.
	localparam int SA_GO       = 4;
	localparam int SA_FUNC_MSB = 6;
	localparam int SA_FUNC_LSB = 8;
	localparam int SA_ENI      = 9;  // Interrupt enable.
	localparam int SA_KEEP_EF  = 10; // Zero here clears EF on DTXA.
	localparam int SA_KEEP_DTF = 11; // Zero here clears DTF on DTXA.

	// Status register B.
	localparam int SB_EF     = 0;
	localparam int SB_TIM    = 5;
	localparam int SB_MF_MSB = 6;
	localparam int SB_MF_LSB = 8;
	localparam int SB_DTF    = 11;

	localparam logic [2:0] FUNC_READ_DATA = 3'o2;

endpackage

`default_nettype wire

/* hw/tc08_tape_pkg.sv */
`default_nettype none

package tc08_tape_pkg;

	////////////////////////////////////////////////////////////
	// Tape data lines.
	////////////////////////////////////////////////////////////

	localparam int LINE_W = 3;

	// One line holds a bit from each of the three data tracks.
	typedef logic [LINE_W-1:0] line_t;

	localparam int LINES_PER_WORD = 4;

	////////////////////////////////////////////////////////////
	// Mark track.
	////////////////////////////////////////////////////////////

	localparam int MARK_W = 6;

	// Newest mark bit sits in bit 0.
	typedef logic [MARK_W-1:0] mark_t;

	// Start of the data area of a block.
	localparam mark_t MARK_DATA  = 6'o70;

	// End of the data area, ahead of the reverse checksum.
	localparam mark_t MARK_FINAL = 6'o73;

endpackage

`default_nettype wire

/* hw/iot_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module iot_regs #(
	parameter tc08_iot_pkg::dev_code_t DEV_A = 6'o76,
	parameter tc08_iot_pkg::dev_code_t DEV_B = 6'o77
) (
	input  wire                      clk,
	input  wire                      i_arst_n,
	input  wire [2:0]                i_iop,
	input  wire tc08_iot_pkg::dev_code_t i_dev_code,
	input  wire tc08_iot_pkg::word_t i_ac,
	input  wire                      i_timing_err,
	input  wire                      i_word_taken,
	input  wire                      i_wc_overflow,
	output tc08_iot_pkg::word_t      o_ac_data,
	output logic                     o_ac_drive,
	output logic                     o_ac_clear,
	output logic                     o_skip,
	output logic                     o_int_rq,
	output logic                     o_read_go,
	output logic [2:0]               o_ea,
	output logic [2:0]               o_unit,
	output logic                     o_go,
	output logic                     o_rev
);

	// Bits of AC that DTRA leaves at zero.
	localparam int SA_PAD = tc08_iot_pkg::WORD_W - 1 - tc08_iot_pkg::SA_ENI;

	logic sel_a;
	logic sel_b;
	logic dtra;
	logic dtca;
	logic dtxa;
	logic dtsf;
	logic dtrb;
	logic dtlb;

	logic [0:tc08_iot_pkg::SA_ENI] sta_q;
	logic [0:tc08_iot_pkg::SA_ENI] sta_d;
	logic [2:0]                    mf_q;
	logic                          tim_q;
	logic                          dtf_q;
	logic                          ef;
	logic                          flag_any;
	tc08_iot_pkg::word_t           stb;

	////////////////////////////////////////////////////////////
	// IOT decode.
	////////////////////////////////////////////////////////////

	assign sel_a = (i_dev_code == DEV_A);
	assign sel_b = (i_dev_code == DEV_B);

	assign dtra = sel_a & i_iop[tc08_iot_pkg::IOP1]; // Read status A.
	assign dtca = sel_a & i_iop[tc08_iot_pkg::IOP2]; // Clear status A.
	assign dtxa = sel_a & i_iop[tc08_iot_pkg::IOP4]; // XOR AC into status A.
	assign dtsf = sel_b & i_iop[tc08_iot_pkg::IOP1]; // Skip on flag.
	assign dtrb = sel_b & i_iop[tc08_iot_pkg::IOP2]; // Read status B.
	assign dtlb = sel_b & i_iop[tc08_iot_pkg::IOP4]; // Load memory field.

	////////////////////////////////////////////////////////////
	// Status registers and flags.
	////////////////////////////////////////////////////////////

	// Clear comes first, so a combined pulse loads AC outright.
	always_comb begin
		sta_d = sta_q;
		if (dtca)
			sta_d = '0;
		if (dtxa)
			sta_d = sta_d ^ i_ac[0:tc08_iot_pkg::SA_ENI];
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sta_q <= '0;
			mf_q  <= '0;
			tim_q <= 1'b0;
			dtf_q <= 1'b0;
		end else begin
			sta_q <= sta_d;

			if (dtlb)
				mf_q <= i_ac[tc08_iot_pkg::SA_FUNC_MSB:tc08_iot_pkg::SA_FUNC_LSB];

			// A new error wins over a clear in the same cycle.
			if (i_timing_err)
				tim_q <= 1'b1;
			else if (dtxa && !i_ac[tc08_iot_pkg::SA_KEEP_EF])
				tim_q <= 1'b0;

			if (i_word_taken && i_wc_overflow)
				dtf_q <= 1'b1; // Last word of the block went to memory.
			else if (dtxa && !i_ac[tc08_iot_pkg::SA_KEEP_DTF])
				dtf_q <= 1'b0;
		end
	end

	// Timing error is the only error source kept.
	assign ef       = tim_q;
	assign flag_any = ef | dtf_q;

	always_comb begin
		stb = '0;
		stb[tc08_iot_pkg::SB_EF]  = ef;
		stb[tc08_iot_pkg::SB_TIM] = tim_q;
		stb[tc08_iot_pkg::SB_MF_MSB:tc08_iot_pkg::SB_MF_LSB] = mf_q;
		stb[tc08_iot_pkg::SB_DTF] = dtf_q;
	end

	////////////////////////////////////////////////////////////
	// Results to the host.
	////////////////////////////////////////////////////////////

	// The host ORs o_ac_data into AC, after a clear when asked.
	always_comb begin
		o_ac_data = '0;
		if (dtra)
			o_ac_data = {sta_q, {SA_PAD{1'b0}}};
		else if (dtrb)
			o_ac_data = stb;
	end

	assign o_ac_drive = dtra | dtrb;
	assign o_ac_clear = dtrb;       // DTRB replaces AC.
	assign o_skip     = dtsf & flag_any;

	assign o_int_rq = sta_q[tc08_iot_pkg::SA_ENI] & flag_any;

	////////////////////////////////////////////////////////////
	// Transport and read path control.
	////////////////////////////////////////////////////////////

	assign o_unit = sta_q[tc08_iot_pkg::SA_UNIT_MSB:tc08_iot_pkg::SA_UNIT_LSB];
	assign o_rev  = sta_q[tc08_iot_pkg::SA_REV];
	assign o_go   = sta_q[tc08_iot_pkg::SA_GO];
	assign o_ea   = mf_q; // Memory field of the break cycles.

	assign o_read_go = sta_q[tc08_iot_pkg::SA_GO] &
		(sta_q[tc08_iot_pkg::SA_FUNC_MSB:tc08_iot_pkg::SA_FUNC_LSB] ==
		tc08_iot_pkg::FUNC_READ_DATA);

endmodule

`default_nettype wire

/* hw/mark_window.sv */
`timescale 1ns/1ps
`default_nettype none

module mark_window (
	input  wire  clk,
	input  wire  i_arst_n,
	input  wire  i_line_strobe,
	input  wire  i_mark_bit,
	output logic o_window
);

	tc08_tape_pkg::mark_t shift_q;
	tc08_tape_pkg::mark_t shift_d;

	// Oldest bit falls off the top.
	assign shift_d = {shift_q[tc08_tape_pkg::MARK_W-2:0], i_mark_bit};

	////////////////////////////////////////////////////////////
	// Mark shift register and data area window.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			shift_q  <= '0;
			o_window <= 1'b0;
		end else if (i_line_strobe) begin
			shift_q <= shift_d;

			// Decided on the window that includes this line's mark bit.
			if (shift_d == tc08_tape_pkg::MARK_DATA)
				o_window <= 1'b1;
			else if (shift_d == tc08_tape_pkg::MARK_FINAL)
				o_window <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/word_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module word_assembler (
	input  wire                        clk,
	input  wire                        i_arst_n,
	input  wire                        i_read_go,
	input  wire                        i_window,
	input  wire                        i_line_strobe,
	input  wire tc08_tape_pkg::line_t  i_line_data,
	input  wire                        i_brk_ack,
	output logic                       o_brk_rq,
	output tc08_iot_pkg::word_t        o_brk_data,
	output logic                       o_timing_err,
	output logic                       o_word_taken
);

	localparam int LINE_W = tc08_tape_pkg::LINE_W;
	localparam int LPW    = tc08_tape_pkg::LINES_PER_WORD;
	localparam int PART_W = (LPW - 1) * LINE_W; // Lines held before the last.
	localparam int CNT_W  = $clog2(LPW);

	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LPW - 1);

	logic                 reading;
	logic                 data_line;
	logic                 word_done;
	logic [CNT_W-1:0]     cnt_q;
	logic [PART_W-1:0]    part_q;
	tc08_iot_pkg::word_t  word_new;

	// Window state is the one from before this strobe.
	assign reading   = i_read_go & i_window;
	assign data_line = reading & i_line_strobe;
	assign word_done = data_line & (cnt_q == CNT_LAST);

	// First line ends up in the most significant bits.
	assign word_new = {part_q, i_line_data};

	////////////////////////////////////////////////////////////
	// Line counter and partial word.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt_q <= '0;
		end else if (!reading) begin
			cnt_q <= '0; // Drop any partial word.
		end else if (data_line) begin
			if (cnt_q == CNT_LAST)
				cnt_q <= '0;
			else
				cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			part_q <= '0;
		else if (data_line)
			part_q <= {part_q[PART_W-LINE_W-1:0], i_line_data};
	end

	////////////////////////////////////////////////////////////
	// Break buffer and handshake.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_brk_rq <= 1'b0;
		else if (word_done)
			o_brk_rq <= 1'b1; // Stays up even when an ack retires the old word.
		else if (i_brk_ack)
			o_brk_rq <= 1'b0;
	end

	// The tape cannot wait, so a pending word is overwritten.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_brk_data <= '0;
		else if (word_done)
			o_brk_data <= word_new;
	end

	assign o_timing_err = word_done & o_brk_rq & ~i_brk_ack;
	assign o_word_taken = o_brk_rq & i_brk_ack;

endmodule

`default_nettype wire

/* hw/tc08_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tc08_ctrl #(
	parameter tc08_iot_pkg::dev_code_t DEV_A = 6'o76, // Status A device.
	parameter tc08_iot_pkg::dev_code_t DEV_B = 6'o77  // Status B device.
) (
	input  wire                          clk,
	input  wire                          i_arst_n,

	// Host I/O bus.
	input  wire [2:0]                    i_iop,
	input  wire tc08_iot_pkg::dev_code_t i_dev_code,
	input  wire tc08_iot_pkg::word_t     i_ac,
	output tc08_iot_pkg::word_t          o_ac_data,
	output logic                         o_ac_drive,
	output logic                         o_ac_clear,
	output logic                         o_skip,
	output logic                         o_int_rq,

	// Data break.
	input  wire                          i_brk_ack,
	input  wire                          i_wc_overflow,
	output logic                         o_brk_rq,
	output tc08_iot_pkg::word_t          o_brk_data,
	output logic [2:0]                   o_ea,

	// Transport.
	output logic [2:0]                   o_unit,
	output logic                         o_go,
	output logic                         o_rev,
	input  wire                          i_line_strobe,
	input  wire tc08_tape_pkg::line_t    i_line_data,
	input  wire                          i_mark_bit
);

	logic read_go;
	logic window;
	logic timing_err;
	logic word_taken;

	////////////////////////////////////////////////////////////
	// IOT decode, status registers and AC return.
	////////////////////////////////////////////////////////////

	iot_regs #(
		.DEV_A (DEV_A),
		.DEV_B (DEV_B)
	) iot_regs_i (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_iop         (i_iop),
		.i_dev_code    (i_dev_code),
		.i_ac          (i_ac),
		.i_timing_err  (timing_err),
		.i_word_taken  (word_taken),
		.i_wc_overflow (i_wc_overflow),
		.o_ac_data     (o_ac_data),
		.o_ac_drive    (o_ac_drive),
		.o_ac_clear    (o_ac_clear),
		.o_skip        (o_skip),
		.o_int_rq      (o_int_rq),
		.o_read_go     (read_go),
		.o_ea          (o_ea),
		.o_unit        (o_unit),
		.o_go          (o_go),
		.o_rev         (o_rev)
	);

	////////////////////////////////////////////////////////////
	// Read path.
	////////////////////////////////////////////////////////////

	mark_window mark_window_i (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_line_strobe (i_line_strobe),
		.i_mark_bit    (i_mark_bit),
		.o_window      (window)
	);

	word_assembler word_assembler_i (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_read_go     (read_go),
		.i_window      (window),
		.i_line_strobe (i_line_strobe),
		.i_line_data   (i_line_data),
		.i_brk_ack     (i_brk_ack),
		.o_brk_rq      (o_brk_rq),
		.o_brk_data    (o_brk_data),
		.o_timing_err  (timing_err),
		.o_word_taken  (word_taken)
	);

endmodule

`default_nettype wire

/* verification/tc08_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tc08_ctrl_tb;

	localparam logic [5:0]  DEV_A_M   = 6'o76;
	localparam logic [5:0]  DEV_B_M   = 6'o77;
	localparam logic [2:0]  P1        = 3'b001;
	localparam logic [2:0]  P2        = 3'b010;
	localparam logic [2:0]  P4        = 3'b100;
	localparam logic [2:0]  FUNC_RD   = 3'o2;
	localparam logic [5:0]  MK_DATA   = 6'o70;
	localparam logic [5:0]  MK_FINAL  = 6'o73;
	localparam logic [31:0] SEED      = 32'd69701;
	localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

	// Stimulus cycles per test, doubled for the limit.
	localparam int RESET_CYC   = 4;
	localparam int IOT_CYC     = 2;
	localparam int LINE_CYC    = 3; // Line, idle and a possible acknowledge.
	localparam int ACK_CYC     = 2;
	localparam int XOR_ROUNDS  = 6;
	localparam int PRE_LINES   = 8;
	localparam int READ_WORDS  = 5;
	localparam int N_IOTS      = (1 + 2 * XOR_ROUNDS) + 6 + 3 + 3 + 7 + 11;
	localparam int N_LINES     = (PRE_LINES + 12 + 4 * READ_WORDS + 4) + 20 + 16;
	localparam int N_ACKS      = 2;
	localparam int CYCLE_LIMIT = 2 * (RESET_CYC + IOT_CYC * N_IOTS +
		LINE_CYC * N_LINES + ACK_CYC * N_ACKS);

	logic        clk;
	logic        i_arst_n;
	logic [2:0]  i_iop;
	logic [5:0]  i_dev_code;
	logic [0:11] i_ac;
	logic [0:11] o_ac_data;
	logic        o_ac_drive;
	logic        o_ac_clear;
	logic        o_skip;
	logic        o_int_rq;
	logic        i_brk_ack;
	logic        i_wc_overflow;
	logic        o_brk_rq;
	logic [0:11] o_brk_data;
	logic [2:0]  o_ea;
	logic [2:0]  o_unit;
	logic        o_go;
	logic        o_rev;
	logic        i_line_strobe;
	logic [2:0]  i_line_data;
	logic        i_mark_bit;

	// Reference model state.
	logic [0:9]  sta_m;
	logic [2:0]  mf_m;
	logic        tim_m;
	logic        dtf_m;
	logic [5:0]  mk_m;
	logic        win_m;
	logic [11:0] part_m;
	int          cnt_m;
	logic        pending_m;
	logic        auto_ack;
	logic [11:0] exp_q[$];

	logic [31:0] lfsr;
	string       test_name;
	int          errors;
	int          checks;
	int          tests;
	int          test_err_start;
	int          cycle_count;

	tc08_ctrl tc08_ctrl_i (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_iop         (i_iop),
		.i_dev_code    (i_dev_code),
		.i_ac          (i_ac),
		.o_ac_data     (o_ac_data),
		.o_ac_drive    (o_ac_drive),
		.o_ac_clear    (o_ac_clear),
		.o_skip        (o_skip),
		.o_int_rq      (o_int_rq),
		.i_brk_ack     (i_brk_ack),
		.i_wc_overflow (i_wc_overflow),
		.o_brk_rq      (o_brk_rq),
		.o_brk_data    (o_brk_data),
		.o_ea          (o_ea),
		.o_unit        (o_unit),
		.o_go          (o_go),
		.o_rev         (o_rev),
		.i_line_strobe (i_line_strobe),
		.i_line_data   (i_line_data),
		.i_mark_bit    (i_mark_bit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers.
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_MASK) : (state >> 1);
	endfunction

	// One LFSR step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int          k;
		val = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [0:11] status_b();
		logic [0:11] w;
		w       = '0;
		w[0]    = tim_m; // EF has only the timing error behind it.
		w[5]    = tim_m;
		w[6:8]  = mf_m;
		w[11]   = dtf_m;
		return w;
	endfunction

	task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s %s: expected %0o, actual %0o", test_name, label, exp, act);
		end
	endtask

	task automatic finish_test();
		tests++;
		$display("%-10s done, %0d errors", test_name, errors - test_err_start);
		test_err_start = errors;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_regs();
		check("unit", sta_m[0:2], o_unit);
		check("rev", sta_m[3], o_rev);
		check("go", sta_m[4], o_go);
		check("ea", mf_m, o_ea);
		check("int_rq", sta_m[9] & (tim_m | dtf_m), o_int_rq);
	endtask

	// One IOT cycle; results are read at the falling edge.
	task automatic iot(input logic [5:0] dev, input logic [2:0] pulse, input logic [0:11] ac);
		logic        is_a;
		logic        is_b;
		logic [0:11] exp_data;
		is_a     = (dev == DEV_A_M);
		is_b     = (dev == DEV_B_M);
		exp_data = '0;
		if (is_a && pulse[0])
			exp_data = {sta_m, 2'b00};
		else if (is_b && pulse[1])
			exp_data = status_b();
		next_cycle();
		i_dev_code = dev;
		i_iop      = pulse;
		i_ac       = ac;
		@(negedge clk);
		check("ac_data", exp_data, o_ac_data);
		check("ac_drive", (is_a & pulse[0]) | (is_b & pulse[1]), o_ac_drive);
		check("ac_clear", is_b & pulse[1], o_ac_clear);
		check("skip", is_b & pulse[0] & (tim_m | dtf_m), o_skip);
		if (is_a && pulse[1])
			sta_m = '0;
		if (is_a && pulse[2]) begin
			sta_m = sta_m ^ ac[0:9];
			if (!ac[10])
				tim_m = 1'b0;
			if (!ac[11])
				dtf_m = 1'b0;
		end
		if (is_b && pulse[2])
			mf_m = ac[6:8];
		next_cycle();
		i_iop = 3'b000; // Pulse ends at the closing edge.
	endtask

	task automatic ack_word(input logic ovf);
		logic [11:0] exp_word;
		i_brk_ack     = 1'b1;
		i_wc_overflow = ovf;
		if (!pending_m || exp_q.size() == 0) begin
			errors++;
			$display("%s: acknowledge sent while no break word was expected", test_name);
		end else begin
			exp_word = exp_q.pop_front();
			check("brk_rq", 1, o_brk_rq);
			check("brk_data", exp_word, o_brk_data);
			if (ovf)
				dtf_m = 1'b1;
		end
		pending_m = 1'b0;
		next_cycle();
		i_brk_ack     = 1'b0;
		i_wc_overflow = 1'b0;
	endtask

	task automatic send_line(input logic mark, input logic [2:0] data);
		logic reading;
		reading = win_m && sta_m[4] && (sta_m[6:8] == FUNC_RD); // Window before the strobe.
		next_cycle();
		i_line_strobe = 1'b1;
		i_mark_bit    = mark;
		i_line_data   = data;
		if (!reading) begin
			cnt_m = 0;
		end else begin
			part_m = {part_m[8:0], data};
			cnt_m++;
			if (cnt_m == 4) begin
				cnt_m = 0;
				if (pending_m) begin
					tim_m = 1'b1; // Old word is lost.
					void'(exp_q.pop_back());
				end
				exp_q.push_back(part_m);
				pending_m = 1'b1;
			end
		end
		mk_m = {mk_m[4:0], mark};
		if (mk_m == MK_DATA)
			win_m = 1'b1;
		else if (mk_m == MK_FINAL)
			win_m = 1'b0;
		next_cycle();
		i_line_strobe = 1'b0;
		check("brk_rq", pending_m, o_brk_rq);
		if (auto_ack && pending_m)
			ack_word(1'b0);
	endtask

	task automatic send_marks(input logic [5:0] pattern);
		int k;
		for (k = 5; k >= 0; k--)
			send_line(pattern[k], 3'(rand_bits(3)));
	endtask

	task automatic send_blank_lines(input int n);
		int k;
		for (k = 0; k < n; k++)
			send_line(1'b0, 3'(rand_bits(3)));
	endtask

	////////////////////////////////////////////////////////////
	// Tests.
	////////////////////////////////////////////////////////////

	initial begin
		logic [0:11] ac;
		logic [5:0]  dev;
		int          k;

		i_arst_n      = 1'b0;
		i_iop         = 3'b000;
		i_dev_code    = '0;
		i_ac          = '0;
		i_brk_ack     = 1'b0;
		i_wc_overflow = 1'b0;
		i_line_strobe = 1'b0;
		i_line_data   = '0;
		i_mark_bit    = 1'b0;
		sta_m         = '0;
		mf_m          = '0;
		tim_m         = 1'b0;
		dtf_m         = 1'b0;
		mk_m          = '0;
		win_m         = 1'b0;
		part_m        = '0;
		cnt_m         = 0;
		pending_m     = 1'b0;
		auto_ack      = 1'b0;
		lfsr          = SEED;
		errors        = 0;
		checks        = 0;
		tests         = 0;
		test_err_start = 0;
		cycle_count   = 0;

		repeat (RESET_CYC) @(posedge clk);
		#2;
		i_arst_n = 1'b1;

		test_name = "status_a";
		check_regs();
		check("brk_rq", 0, o_brk_rq);
		iot(DEV_A_M, P2, '0);
		for (k = 0; k < XOR_ROUNDS; k++) begin
			iot(DEV_A_M, P4, 12'(rand_bits(12)));
			iot(DEV_A_M, P1, '0);
			check_regs();
		end
		finish_test();

		test_name = "mem_field";
		for (k = 0; k < 3; k++) begin
			iot(DEV_B_M, P4, 12'(rand_bits(12)));
			iot(DEV_B_M, P2, '0);
			check_regs();
		end
		finish_test();

		// GO with the read function, flags kept.
		test_name = "read_path";
		ac         = '0;
		ac[0:2]    = 3'(rand_bits(3));
		ac[4]      = 1'b1;
		ac[6:8]    = FUNC_RD;
		ac[10]     = 1'b1;
		ac[11]     = 1'b1;
		iot(DEV_A_M, P2, '0);
		iot(DEV_A_M, P4, ac);
		check_regs();
		auto_ack = 1'b1;
		for (k = 0; k < PRE_LINES; k++)
			send_line(rand_bits(1) != 0, 3'(rand_bits(3)));
		send_marks(MK_DATA);
		send_blank_lines(4 * READ_WORDS);
		send_marks(MK_FINAL);
		send_blank_lines(4);
		iot(DEV_B_M, P2, '0);
		finish_test();

		test_name = "timing";
		auto_ack = 1'b0;
		send_marks(MK_DATA);
		send_blank_lines(8); // Two words, no acknowledge.
		iot(DEV_B_M, P2, '0);
		iot(DEV_B_M, P1, '0);
		check_regs();
		ac     = '0;
		ac[9]  = 1'b1;
		ac[10] = 1'b1;
		ac[11] = 1'b1;
		iot(DEV_A_M, P4, ac);
		check_regs();
		ack_word(1'b0);
		auto_ack = 1'b1;
		send_marks(MK_FINAL);
		finish_test();

		test_name = "flags";
		auto_ack = 1'b0;
		send_marks(MK_DATA);
		send_blank_lines(4);
		ack_word(1'b1); // Word count overflow sets DTF.
		iot(DEV_B_M, P2, '0);
		iot(DEV_B_M, P1, '0);
		iot(DEV_A_M, P4, 12'o0002);
		iot(DEV_B_M, P2, '0);
		iot(DEV_A_M, P4, 12'o0001);
		iot(DEV_B_M, P2, '0);
		iot(DEV_B_M, P1, '0);
		check_regs();
		auto_ack = 1'b1;
		send_marks(MK_FINAL);
		finish_test();

		test_name = "foreign";
		for (k = 0; k < 8; k++) begin
			dev = 6'(rand_bits(6));
			if (dev == DEV_A_M || dev == DEV_B_M)
				dev = dev ^ 6'o10;
			iot(dev, 3'(rand_bits(3)), 12'(rand_bits(12)));
		end
		iot(DEV_A_M, P1, '0);
		iot(DEV_B_M, P2, '0);
		iot(DEV_B_M, P1, '0);
		check_regs();
		finish_test();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/tc08_iot_pkg.sv
hw/tc08_tape_pkg.sv
hw/iot_regs.sv
hw/mark_window.sv
hw/word_assembler.sv
hw/tc08_ctrl.sv
verification/tc08_ctrl_tb.sv
